//--- rtl/lineEnginePkg.sv
package lineEnginePkg;

	// coordinate space is 1024 x 1024
	localparam int coordW = 10;
	// 8'h00, R, G, B
	localparam int colorW = 32;
	localparam int addrW = 31;
	// one write beat plus its active-low byte mask
	localparam int dataW = 128;
	localparam int maskW = 16;

	// host-programmed line parameters
	typedef struct packed {
		logic [coordW-1:0] x0;
		logic [coordW-1:0] y0;
		logic [coordW-1:0] x1;
		logic [coordW-1:0] y1;
		logic [colorW-1:0] color;
		logic [31:0] frameBase;
	} lineCmd;

	// line after the steep swap and endpoint ordering
	typedef struct packed {
		logic steep;
		logic [coordW-1:0] startX;
		logic [coordW-1:0] startY;
		logic [coordW-1:0] endX;
		logic [coordW-1:0] deltaX;
		logic [coordW-1:0] deltaY;
		// set when the minor axis counts down
		logic yStep;
	} lineGeom;

	// current pixel, major axis always increasing
	typedef struct packed {
		logic [coordW-1:0] major;
		logic [coordW-1:0] minor;
		logic steep;
	} pixelPos;

	typedef enum logic [2:0] {
		IDLE,
		SETUP,
		SEND1,
		SEND2,
		UPDATE
	} ctrlState;

endpackage

//--- rtl/lineRegs.sv
`timescale 1ns/10ps

module lineRegs import lineEnginePkg::*; (
	input logic clk,
	input logic rst,
	input logic [coordW-1:0] point,
	input logic x0Valid,
	input logic y0Valid,
	input logic x1Valid,
	input logic y1Valid,
	input logic colorValid,
	input logic [colorW-1:0] color,
	input logic trigger,
	input logic [31:0] frameBase,
	output lineCmd cmd
);

	// each field has its own strobe, so several can land in one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			cmd <= '0;
		end else begin
			if (x0Valid) begin
				cmd.x0 <= point;
			end
			if (y0Valid) begin
				cmd.y0 <= point;
			end
			if (x1Valid) begin
				cmd.x1 <= point;
			end
			if (y1Valid) begin
				cmd.y1 <= point;
			end
			if (colorValid) begin
				cmd.color <= color;
			end
			// frame base follows each trigger so the host may move it per line
			if (trigger) begin
				cmd.frameBase <= frameBase;
			end
		end
	end

endmodule

//--- rtl/lineSetup.sv
`timescale 1ns/10ps

module lineSetup import lineEnginePkg::*; (
	input logic clk,
	input logic rst,
	input lineCmd cmd,
	input logic loadGeom,
	output lineGeom geom
);

	logic [coordW-1:0] absDx;
	logic [coordW-1:0] absDy;
	logic steep;
	logic [coordW-1:0] a0;
	logic [coordW-1:0] b0;
	logic [coordW-1:0] a1;
	logic [coordW-1:0] b1;
	lineGeom nextGeom;

	assign absDx = (cmd.x1 > cmd.x0) ? cmd.x1 - cmd.x0 : cmd.x0 - cmd.x1;
	assign absDy = (cmd.y1 > cmd.y0) ? cmd.y1 - cmd.y0 : cmd.y0 - cmd.y1;
	assign steep = absDy > absDx;

	// a is the major axis, b the minor one
	assign a0 = steep ? cmd.y0 : cmd.x0;
	assign b0 = steep ? cmd.x0 : cmd.y0;
	assign a1 = steep ? cmd.y1 : cmd.x1;
	assign b1 = steep ? cmd.x1 : cmd.y1;

	always_comb begin
		nextGeom.steep = steep;
		// draw from the lower major coordinate upward
		if (a0 > a1) begin
			nextGeom.startX = a1;
			nextGeom.startY = b1;
			nextGeom.endX = a0;
			nextGeom.yStep = b1 > b0;
		end else begin
			nextGeom.startX = a0;
			nextGeom.startY = b0;
			nextGeom.endX = a1;
			nextGeom.yStep = b0 > b1;
		end
		nextGeom.deltaX = nextGeom.endX - nextGeom.startX;
		nextGeom.deltaY = (b1 > b0) ? b1 - b0 : b0 - b1;
	end

	// held stable for the whole line while the host reloads cmd
	always_ff @(posedge clk) begin
		if (rst) begin
			geom <= '0;
		end else if (loadGeom) begin
			geom <= nextGeom;
		end
	end

endmodule

//--- rtl/bresenhamStepper.sv
`timescale 1ns/10ps

module bresenhamStepper import lineEnginePkg::*; (
	input logic clk,
	input logic rst,
	input lineGeom geom,
	input logic loadStart,
	input logic step,
	output pixelPos pos,
	output logic lastPixel
);

	// error term stays in [0, deltaX) so it needs no sign bit
	logic [coordW-1:0] err;
	logic minorMove;

	assign minorMove = err < geom.deltaY;

	always_ff @(posedge clk) begin
		if (rst) begin
			pos <= '0;
			err <= '0;
		end else if (loadStart) begin
			pos.major <= geom.startX;
			pos.minor <= geom.startY;
			pos.steep <= geom.steep;
			err <= geom.deltaX >> 1;
		end else if (step) begin
			pos.major <= pos.major + 1'b1;
			if (minorMove) begin
				if (geom.yStep) begin
					pos.minor <= pos.minor - 1'b1;
				end else begin
					pos.minor <= pos.minor + 1'b1;
				end
				err <= err + geom.deltaX - geom.deltaY;
			end else begin
				err <= err - geom.deltaY;
			end
		end
	end

	// sampled by the controller in UPDATE, before the step lands
	assign lastPixel = pos.major >= geom.endX;

endmodule

//--- rtl/pixelWriter.sv
`timescale 1ns/10ps

module pixelWriter import lineEnginePkg::*; (
	input lineCmd cmd,
	input pixelPos pos,
	input logic beatHigh,
	output logic [addrW-1:0] afAddr,
	output logic [dataW-1:0] wdfData,
	output logic [maskW-1:0] wdfMask
);

	logic [coordW-1:0] row;
	logic [coordW-1:0] col;
	logic [2:0] lane;
	// byte enables across the full 32-byte block, active high
	logic [2*maskW-1:0] laneEn;

	// a steep line runs along y, so major is the screen row
	assign row = pos.steep ? pos.major : pos.minor;
	assign col = pos.steep ? pos.minor : pos.major;

	// 8-pixel block address, 32 bytes per block
	assign afAddr = {6'b0, cmd.frameBase[27:22], row, col[coordW-1:3], 2'b0};

	assign lane = col[2:0];
	assign laneEn = {4'hf, {(2*maskW-4){1'b0}}} >> {lane, 2'b00};

	// lanes 0-3 go out in the upper beat, lanes 4-7 in the lower one
	assign wdfMask = beatHigh ? ~laneEn[2*maskW-1:maskW] : ~laneEn[maskW-1:0];

	assign wdfData = {4{cmd.color}};

endmodule

//--- rtl/lineControl.sv
`timescale 1ns/10ps

module lineControl import lineEnginePkg::*; (
	input logic clk,
	input logic rst,
	input logic trigger,
	input logic afFull,
	input logic wdfFull,
	input logic lastPixel,
	output logic ready,
	output logic loadGeom,
	output logic loadStart,
	output logic step,
	output logic beatHigh,
	output logic afWrEn,
	output logic wdfWrEn
);

	ctrlState state;
	ctrlState nextState;
	logic send1Go;
	logic send2Go;

	// address and upper beat need room in both FIFOs at once
	assign send1Go = (state == SEND1) && !afFull && !wdfFull;
	assign send2Go = (state == SEND2) && !wdfFull;

	always_comb begin
		nextState = state;
		case (state)
			IDLE: begin
				if (trigger) begin
					nextState = SETUP;
				end
			end
			SETUP: nextState = SEND1;
			SEND1: begin
				if (send1Go) begin
					nextState = SEND2;
				end
			end
			SEND2: begin
				if (send2Go) begin
					nextState = UPDATE;
				end
			end
			UPDATE: nextState = lastPixel ? IDLE : SEND1;
			default: nextState = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	assign ready = state == IDLE;
	// trigger while busy falls through here
	assign loadGeom = ready && trigger;
	assign loadStart = state == SETUP;
	assign step = state == UPDATE;
	assign beatHigh = state == SEND1;
	assign afWrEn = send1Go;
	assign wdfWrEn = send1Go || send2Go;

endmodule

//--- rtl/lineEngine.sv
`timescale 1ns/10ps

module lineEngine import lineEnginePkg::*; (
	input logic clk,
	input logic rst,
	input logic [coordW-1:0] point,
	input logic x0Valid,
	input logic y0Valid,
	input logic x1Valid,
	input logic y1Valid,
	input logic colorValid,
	input logic [colorW-1:0] color,
	input logic trigger,
	input logic [31:0] frameBase,
	output logic ready,
	input logic afFull,
	input logic wdfFull,
	output logic [addrW-1:0] afAddr,
	output logic afWrEn,
	output logic [dataW-1:0] wdfData,
	output logic [maskW-1:0] wdfMask,
	output logic wdfWrEn
);

	lineCmd cmd;
	lineGeom geom;
	pixelPos pos;
	logic loadGeom;
	logic loadStart;
	logic step;
	logic beatHigh;
	logic lastPixel;

	// only a trigger taken in IDLE may move the frame base
	lineRegs i_lineRegs (
		.clk(clk),
		.rst(rst),
		.point(point),
		.x0Valid(x0Valid),
		.y0Valid(y0Valid),
		.x1Valid(x1Valid),
		.y1Valid(y1Valid),
		.colorValid(colorValid),
		.color(color),
		.trigger(loadGeom),
		.frameBase(frameBase),
		.cmd(cmd)
	);

	lineSetup i_lineSetup (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.loadGeom(loadGeom),
		.geom(geom)
	);

	bresenhamStepper i_bresenhamStepper (
		.clk(clk),
		.rst(rst),
		.geom(geom),
		.loadStart(loadStart),
		.step(step),
		.pos(pos),
		.lastPixel(lastPixel)
	);

	pixelWriter i_pixelWriter (
		.cmd(cmd),
		.pos(pos),
		.beatHigh(beatHigh),
		.afAddr(afAddr),
		.wdfData(wdfData),
		.wdfMask(wdfMask)
	);

	lineControl i_lineControl (
		.clk(clk),
		.rst(rst),
		.trigger(trigger),
		.afFull(afFull),
		.wdfFull(wdfFull),
		.lastPixel(lastPixel),
		.ready(ready),
		.loadGeom(loadGeom),
		.loadStart(loadStart),
		.step(step),
		.beatHigh(beatHigh),
		.afWrEn(afWrEn),
		.wdfWrEn(wdfWrEn)
	);

endmodule

//--- tb/lineControl_checker.sv
`timescale 1ns/10ps

module lineControl_checker import lineEnginePkg::*; (
	input logic clk,
	input logic rst,
	input ctrlState state,
	input logic ready,
	input logic afFull,
	input logic wdfFull,
	input logic afWrEn,
	input logic wdfWrEn
);

	int failCount = 0;

	afFullGuard: assert property (@(posedge clk) disable iff (rst) afFull |-> !afWrEn)
	else begin
		failCount++;
		$error("address FIFO written while afFull is high");
	end

	wdfFullGuard: assert property (@(posedge clk) disable iff (rst) wdfFull |-> !wdfWrEn)
	else begin
		failCount++;
		$error("write-data FIFO written while wdfFull is high");
	end

	// an address always travels with its upper beat
	addrWithBeat: assert property (@(posedge clk) disable iff (rst) afWrEn |-> wdfWrEn)
	else begin
		failCount++;
		$error("address written without a data beat");
	end

	// ready comes back only out of the last pixel's UPDATE
	readyAfterUpdate: assert property (@(posedge clk) disable iff (rst)
		$rose(ready) |-> $past(state) == UPDATE)
	else begin
		failCount++;
		$error("ready rose without an UPDATE just before it");
	end

endmodule

bind lineControl lineControl_checker i_lineControlChecker (
	.clk(clk),
	.rst(rst),
	.state(state),
	.ready(ready),
	.afFull(afFull),
	.wdfFull(wdfFull),
	.afWrEn(afWrEn),
	.wdfWrEn(wdfWrEn)
);

//--- tb/lineEngineMonitor.sv
`timescale 1ns/10ps

module lineEngineMonitor import lineEnginePkg::*; (
	input logic clk,
	input logic rst,
	input logic afWrEn,
	input logic [addrW-1:0] afAddr,
	input logic wdfWrEn,
	input logic [dataW-1:0] wdfData,
	input logic [maskW-1:0] wdfMask,
	output int valueErrors,
	output int countErrors
);

	logic [addrW-1:0] addrQ[$];
	logic [maskW-1:0] maskQ[$];
	logic [dataW-1:0] dataQ[$];
	logic [addrW-1:0] wantAddr;
	logic [maskW-1:0] wantMask;
	logic [dataW-1:0] wantData;

	// one address and two beats per pixel, upper beat first
	function automatic void expectPixel(input logic [addrW-1:0] addr,
			input logic [maskW-1:0] maskHi, input logic [maskW-1:0] maskLo,
			input logic [dataW-1:0] data);
		addrQ.push_back(addr);
		maskQ.push_back(maskHi);
		dataQ.push_back(data);
		maskQ.push_back(maskLo);
		dataQ.push_back(data);
	endfunction

	function automatic int missingWrites();
		return addrQ.size() + maskQ.size();
	endfunction

	// enables and data have settled by the falling edge
	always @(negedge clk) begin
		if (rst) begin
			valueErrors = 0;
			countErrors = 0;
		end else begin
			if (afWrEn) begin
				if (addrQ.size() == 0) begin
					$display("address write with no pixel left to draw, afAddr %h", afAddr);
					countErrors++;
				end else begin
					wantAddr = addrQ.pop_front();
					if (afAddr !== wantAddr) begin
						$display("Fail afAddr expected %h got %h", wantAddr, afAddr);
						valueErrors++;
					end
				end
			end
			if (wdfWrEn) begin
				if (maskQ.size() == 0) begin
					$display("data beat written with no beat left to expect");
					countErrors++;
				end else begin
					wantMask = maskQ.pop_front();
					wantData = dataQ.pop_front();
					if (wdfMask !== wantMask) begin
						$display("Fail wdfMask expected %h got %h", wantMask, wdfMask);
						valueErrors++;
					end
					if (wdfData !== wantData) begin
						$display("Fail wdfData expected %h got %h", wantData, wdfData);
						valueErrors++;
					end
				end
			end
		end
	end

endmodule

//--- tb/lineEngineTb.sv
`timescale 1ns/10ps

module lineEngineTb import lineEnginePkg::*; ();

	logic clk;
	logic rst;
	logic [coordW-1:0] point;
	logic x0Valid;
	logic y0Valid;
	logic x1Valid;
	logic y1Valid;
	logic colorValid;
	logic [colorW-1:0] color;
	logic trigger;
	logic [31:0] frameBase;
	logic ready;
	logic afFull;
	logic wdfFull;
	logic [addrW-1:0] afAddr;
	logic afWrEn;
	logic [dataW-1:0] wdfData;
	logic [maskW-1:0] wdfMask;
	logic wdfWrEn;

	int valueErrors;
	int countErrors;
	int tbErrors = 0;
	int timeouts = 0;
	int cycles = 0;
	int timeoutLimit = 200;
	int unsigned seed = 15;
	bit stallOn = 0;
	int lineArgs [12][4];

	lineEngine i_lineEngine (.*);

	lineEngineMonitor i_lineEngineMonitor (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic int unsigned nextRand();
		seed = seed * 1103515245 + 12345;
		return seed >> 16;
	endfunction

	// plain Bresenham on ints that pushes one address and two masked beats per pixel
	function automatic int drawLineRef(input int x0, input int y0, input int x1, input int y1,
			input logic [31:0] lineColor, input logic [31:0] base);
		int ax0;
		int ay0;
		int ax1;
		int ay1;
		int t;
		int dx;
		int dy;
		int err;
		int yStep;
		int y;
		int row;
		int col;
		int lane;
		bit steep;
		logic [15:0] laneBits;
		logic [addrW-1:0] addr;
		dx = (x1 > x0) ? x1 - x0 : x0 - x1;
		dy = (y1 > y0) ? y1 - y0 : y0 - y1;
		steep = dy > dx;
		ax0 = steep ? y0 : x0;
		ay0 = steep ? x0 : y0;
		ax1 = steep ? y1 : x1;
		ay1 = steep ? x1 : y1;
		if (ax0 > ax1) begin
			t = ax0;
			ax0 = ax1;
			ax1 = t;
			t = ay0;
			ay0 = ay1;
			ay1 = t;
		end
		dx = ax1 - ax0;
		dy = (ay1 > ay0) ? ay1 - ay0 : ay0 - ay1;
		yStep = (ay0 < ay1) ? 1 : -1;
		err = dx / 2;
		y = ay0;
		for (int x = ax0; x <= ax1; x++) begin
			row = steep ? x : y;
			col = steep ? y : x;
			lane = col % 8;
			laneBits = 16'hF000 >> (4 * (lane % 4));
			addr = addrW'(int'(base[27:22]) * 524288 + row * 512 + (col / 8) * 4);
			i_lineEngineMonitor.expectPixel(addr, (lane < 4) ? ~laneBits : 16'hFFFF,
				(lane < 4) ? 16'hFFFF : ~laneBits, {4{lineColor}});
			err = err - dy;
			if (err < 0) begin
				y = y + yStep;
				err = err + dx;
			end
		end
		return dx + 1;
	endfunction

	task automatic finishRun();
		int assertFails;
		int missing;
		assertFails = i_lineEngine.i_lineControl.i_lineControlChecker.failCount;
		missing = i_lineEngineMonitor.missingWrites();
		if (missing > 0) begin
			$display("%0d expected writes never appeared", missing);
		end
		$display("errors: value %0d, write count %0d, assertion %0d, testbench %0d, timeout %0d",
			valueErrors, countErrors + missing, assertFails, tbErrors, timeouts);
		if (valueErrors + countErrors + missing + assertFails + tbErrors + timeouts == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > timeoutLimit) begin
			$display("timeout after %0d cycles, the engine did not finish its lines", cycles);
			timeouts = 1;
			finishRun();
		end
	end

	// full flags go high about one cycle in four
	initial begin
		forever begin
			@(posedge clk);
			#1;
			afFull = stallOn && (nextRand() % 4 == 0);
			wdfFull = stallOn && (nextRand() % 4 == 0);
		end
	end

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic strobeCoord(input int sel, input int value);
		point = coordW'(value);
		x0Valid = sel == 0;
		y0Valid = sel == 1;
		x1Valid = sel == 2;
		y1Valid = sel == 3;
		nextCycle();
		x0Valid = 1'b0;
		y0Valid = 1'b0;
		x1Valid = 1'b0;
		y1Valid = 1'b0;
	endtask

	task automatic drawLine(input int x0, input int y0, input int x1, input int y1,
			input logic [31:0] lineColor, input logic [31:0] base, input bit pokeBusy);
		int pixels;
		int busy;
		// color and frame base feed the live line, so load only when idle
		while (!ready) begin
			nextCycle();
		end
		pixels = drawLineRef(x0, y0, x1, y1, lineColor, base);
		timeoutLimit += 20 * pixels;
		strobeCoord(0, x0);
		strobeCoord(1, y0);
		strobeCoord(2, x1);
		strobeCoord(3, y1);
		color = lineColor;
		colorValid = 1'b1;
		nextCycle();
		colorValid = 1'b0;
		frameBase = base;
		trigger = 1'b1;
		nextCycle();
		trigger = 1'b0;
		busy = 0;
		while (!ready) begin
			busy++;
			// a trigger mid-line must neither start anything nor move the frame base
			trigger = pokeBusy && busy == 4;
			frameBase = (pokeBusy && busy == 4) ? ~base : base;
			nextCycle();
		end
		trigger = 1'b0;
		frameBase = base;
		if (!stallOn && busy != 3 * pixels + 1) begin
			$display("ready stayed low for %0d cycles, expected %0d", busy, 3 * pixels + 1);
			tbErrors++;
		end
		repeat (3) nextCycle();
	endtask

	initial begin
		int a;
		int b;
		int da;
		int db;
		rst = 1'b1;
		point = '0;
		x0Valid = 1'b0;
		y0Valid = 1'b0;
		x1Valid = 1'b0;
		y1Valid = 1'b0;
		colorValid = 1'b0;
		color = '0;
		trigger = 1'b0;
		frameBase = '0;
		afFull = 1'b0;
		wdfFull = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		if (ready !== 1'b1) begin
			$display("Fail ready expected %h got %h", 1'b1, ready);
			tbErrors++;
		end
		if (afWrEn !== 1'b0 || wdfWrEn !== 1'b0) begin
			$display("Fail afWrEn/wdfWrEn expected %h got %h", 2'b00, {afWrEn, wdfWrEn});
			tbErrors++;
		end
		// random endpoints drawn up front and kept inside the screen
		for (int i = 0; i < 12; i++) begin
			a = int'(nextRand() % 900) + 50;
			b = int'(nextRand() % 900) + 50;
			da = int'(nextRand() % 50);
			db = int'(nextRand() % 50);
			lineArgs[i][0] = a;
			lineArgs[i][1] = b;
			lineArgs[i][2] = (nextRand() % 2 == 0) ? a + da : a - da;
			lineArgs[i][3] = (nextRand() % 2 == 0) ? b + db : b - db;
		end
		drawLine(10, 20, 45, 31, 32'h00AA5533, 32'h0A400000, 1'b0);
		drawLine(45, 31, 10, 20, 32'h0011EE77, 32'h0BC00000, 1'b0);
		// steep line where x falls as y rises
		drawLine(300, 350, 290, 400, 32'h00FF0080, 32'h0D400000, 1'b0);
		drawLine(7, 7, 7, 7, 32'h00123456, 32'h0FC00000, 1'b0);
		drawLine(100, 500, 130, 488, 32'h00C0FFEE, 32'h08400000, 1'b1);
		stallOn = 1'b1;
		for (int i = 0; i < 12; i++) begin
			drawLine(lineArgs[i][0], lineArgs[i][1], lineArgs[i][2], lineArgs[i][3],
				32'h00FFFFFF & (32'h00135799 * (i + 1)),
				32'hF0000155 | ((i + 5) << 22), i % 3 == 0);
		end
		stallOn = 1'b0;
		repeat (5) nextCycle();
		finishRun();
	end

endmodule

//--- list.f
rtl/lineEnginePkg.sv
rtl/lineRegs.sv
rtl/lineSetup.sv
rtl/bresenhamStepper.sv
rtl/pixelWriter.sv
rtl/lineControl.sv
rtl/lineEngine.sv
tb/lineControl_checker.sv
tb/lineEngineMonitor.sv
tb/lineEngineTb.sv

//--- Makefile
.PHONY: compile run clean

SIM = obj_dir/lineEngineSim

compile:
	verilator --binary --timing --assert --top-module lineEngineTb \
		-f list.f -Mdir obj_dir -o lineEngineSim

run: compile
	./$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
